// File: hdl/uart_pkg.sv
package uart_pkg;

    // Serial timing. 48 clocks per bit gives 1 Mbaud from a 48 MHz clock.
    localparam int CLKS_PER_BIT   = 48;
    localparam int STARTUP_CYCLES = 200;  // Kept short so simulation runs quickly.
    localparam int DATA_BITS      = 8;

    typedef enum logic [1:0] {
        PARITY_NONE,
        PARITY_EVEN,
        PARITY_ODD
    } parity_e;

    localparam parity_e PARITY_MODE = PARITY_EVEN;

    // Start bit, data bits, optional parity bit and one stop bit.
    localparam int FRAME_BITS = 2 + DATA_BITS + ((PARITY_MODE != PARITY_NONE) ? 1 : 0);

    // Counter widths and terminal counts derived from the frame format.
    localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [BAUD_CNT_W-1:0] BAUD_LAST = BAUD_CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [BAUD_CNT_W-1:0] HALF_LAST = BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1);

    localparam int BIT_IDX_W = $clog2(DATA_BITS);
    localparam logic [BIT_IDX_W-1:0] BIT_LAST = BIT_IDX_W'(DATA_BITS - 1);

    localparam int STARTUP_CNT_W = $clog2(STARTUP_CYCLES);
    localparam logic [STARTUP_CNT_W-1:0] STARTUP_LAST = STARTUP_CNT_W'(STARTUP_CYCLES - 1);

    typedef struct packed {
        logic [7:0] data;
        logic       parity_error;
    } rx_result_t;

    typedef struct packed {
        logic       running;      // Sequencer has left start-up.
        logic [7:0] last_byte;
        logic [7:0] rx_count;     // Wraps modulo 256.
        logic       parity_seen;  // Sticky until reset.
    } link_status_t;

    // Parity bit that goes with a data byte in the configured mode.
    function automatic logic parity_bit(input logic [7:0] d);
        logic p;
        case (PARITY_MODE)
            PARITY_EVEN: p = ^d;
            PARITY_ODD:  p = ~^d;
            default:     p = 1'b0;
        endcase
        return p;
    endfunction

endpackage

// File: hdl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] tx_data,
    input  logic       start_tx,
    output logic       tx,
    output logic       tx_busy
);
    import uart_pkg::*;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_e;

    tx_state_e             state;
    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [BIT_IDX_W-1:0]  bit_idx;
    logic [7:0]            shift_q;
    logic                  parity_q;
    logic                  bit_end;
    logic                  launch;

    assign bit_end = (baud_cnt == BAUD_LAST);
    assign launch  = (state == TX_IDLE) && start_tx;

    // The line is registered, so each bit starts on a clock edge and lasts
    // exactly CLKS_PER_BIT cycles.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx       <= 1'b1;
            tx_busy  <= 1'b0;
        end else begin
            if (state == TX_IDLE || bit_end) begin
                baud_cnt <= '0;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end

            case (state)
                TX_IDLE: begin
                    if (launch) begin
                        state   <= TX_START;
                        tx      <= 1'b0;  // Start bit goes out with busy.
                        tx_busy <= 1'b1;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                        tx      <= shift_q[0];
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == BIT_LAST) begin
                            if (PARITY_MODE != PARITY_NONE) begin
                                state <= TX_PARITY;
                                tx    <= parity_q;
                            end else begin
                                state <= TX_STOP;
                                tx    <= 1'b1;
                            end
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shift_q[1];  // Shift happens on this same edge.
                        end
                    end
                end
                TX_PARITY: begin
                    if (bit_end) begin
                        state <= TX_STOP;
                        tx    <= 1'b1;
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        state   <= TX_IDLE;
                        tx_busy <= 1'b0;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Byte and parity are captured when the frame is launched.
    always_ff @(posedge clk) begin
        if (launch) begin
            shift_q  <= tx_data;
            parity_q <= parity_bit(tx_data);
        end else if (state == TX_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

// File: hdl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rx,
    output uart_pkg::rx_result_t rx_result,
    output logic                 rx_done
);
    import uart_pkg::*;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

    rx_state_e             state;
    logic                  rx_meta;
    logic                  rx_sync;
    logic                  rx_prev;
    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [BIT_IDX_W-1:0]  bit_idx;
    logic [7:0]            shift_q;
    logic                  parity_rx_q;
    logic                  fall;
    logic                  bit_end;
    logic                  half_end;

    assign fall     = rx_prev & ~rx_sync;
    assign bit_end  = (baud_cnt == BAUD_LAST);
    assign half_end = (baud_cnt == HALF_LAST);

    // Two flops bring rx into the clock domain; a third gives the edge.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_done  <= 1'b0;
        end else begin
            rx_done  <= 1'b0;
            baud_cnt <= baud_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (fall) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Half a bit in, the line must still be low.
                    if (half_end) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == BIT_LAST) begin
                            state <= (PARITY_MODE != PARITY_NONE) ? RX_PARITY : RX_STOP;
                        end
                    end
                end
                RX_PARITY: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        state    <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin  // Middle of the stop bit.
                        state   <= RX_IDLE;
                        rx_done <= 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data arrives LSB first, so it enters at the top and shifts down.
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
        if (state == RX_PARITY && bit_end) begin
            parity_rx_q <= rx_sync;
        end
        if (state == RX_STOP && bit_end) begin
            rx_result.data         <= shift_q;
            rx_result.parity_error <= (PARITY_MODE != PARITY_NONE) &&
                                      (parity_rx_q != parity_bit(shift_q));
        end
    end

endmodule

// File: hdl/code_sequencer.sv
`timescale 1ns/1ps

module code_sequencer (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_busy,
    output logic [7:0] tx_data,
    output logic       start_tx,
    output logic       running
);
    import uart_pkg::*;

    typedef enum logic {
        SEQ_STARTUP,
        SEQ_STREAM
    } seq_state_e;

    seq_state_e               state;
    logic [STARTUP_CNT_W-1:0] wait_cnt;
    logic [5:0]               code;
    logic                     busy_q;
    logic                     tx_done;

    assign tx_done = busy_q & ~tx_busy;  // Transmitter has just gone idle.
    assign tx_data = {2'b00, code};
    assign running = (state == SEQ_STREAM);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= SEQ_STARTUP;
            wait_cnt <= '0;
            code     <= '0;
            busy_q   <= 1'b0;
            start_tx <= 1'b0;
        end else begin
            busy_q   <= tx_busy;
            start_tx <= 1'b0;
            // The code is on tx_data during the pulse and advances right after.
            if (start_tx) begin
                code <= code + 1'b1;
            end
            case (state)
                SEQ_STARTUP: begin
                    if (wait_cnt == STARTUP_LAST) begin
                        state    <= SEQ_STREAM;
                        start_tx <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                SEQ_STREAM: begin
                    if (tx_done) begin
                        start_tx <= 1'b1;
                    end
                end
                default: state <= SEQ_STARTUP;
            endcase
        end
    end

endmodule

// File: hdl/link_status.sv
`timescale 1ns/1ps

module link_status (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   running,
    input  uart_pkg::rx_result_t   rx_result,
    input  logic                   rx_done,
    output uart_pkg::link_status_t status
);

    // Everything here is what the board shows on its LEDs and debug pins.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status <= '0;
        end else begin
            status.running <= running;
            if (rx_done) begin
                status.last_byte <= rx_result.data;
                status.rx_count  <= status.rx_count + 8'd1;  // Wraps at 256.
                // Only reset clears the parity flag.
                if (rx_result.parity_error) begin
                    status.parity_seen <= 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/uart_link_top.sv
`timescale 1ns/1ps

module uart_link_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rx,
    output logic                   tx,
    output uart_pkg::rx_result_t   rx_result,
    output logic                   rx_done,
    output uart_pkg::link_status_t status
);

    logic [7:0] tx_data;
    logic       start_tx;
    logic       tx_busy;
    logic       running;

    // Transmit path. The sequencer streams codes whenever the transmitter is idle.
    code_sequencer u_sequencer (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_busy  (tx_busy),
        .tx_data  (tx_data),
        .start_tx (start_tx),
        .running  (running)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .start_tx (start_tx),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

    // Receive path runs on its own.
    uart_rx u_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx        (rx),
        .rx_result (rx_result),
        .rx_done   (rx_done)
    );

    link_status u_status (
        .clk       (clk),
        .rst_n     (rst_n),
        .running   (running),
        .rx_result (rx_result),
        .rx_done   (rx_done),
        .status    (status)
    );

endmodule

// File: include/uart_tb_model.svh
`ifndef UART_TB_MODEL_SVH
`define UART_TB_MODEL_SVH

// Reference model state, updated as frames are checked.
logic [5:0] exp_code;         // Next code the sequencer should send.
logic [7:0] exp_rx_count;     // Wraps at 256 like the status counter.
logic [7:0] exp_last_byte;
logic       exp_parity_seen;
logic       seq_started;      // Set once the first start bit shows on tx.

// Parity bit that gives the frame the count of ones its mode asks for.
function automatic logic expected_parity(input logic [7:0] d);
    int ones;
    ones = 0;
    for (int i = 0; i < DATA_BITS; i++) begin
        ones += d[i];
    end
    if (PARITY_MODE == PARITY_ODD) begin
        return (ones % 2) == 0;
    end
    return (ones % 2) == 1;
endfunction

// One bit period on rx. Entered and left 1 ns after a rising edge.
task automatic drive_rx_bit(input logic b);
    rx = b;
    repeat (CLKS_PER_BIT) @(posedge clk);
    #1;
endtask

task automatic send_rx_frame(input logic [7:0] data, input logic bad_parity);
    drive_rx_bit(1'b0);
    for (int i = 0; i < DATA_BITS; i++) begin
        drive_rx_bit(data[i]);  // LSB first.
    end
    if (PARITY_MODE != PARITY_NONE) begin
        drive_rx_bit(expected_parity(data) ^ bad_parity);
    end
    drive_rx_bit(1'b1);
endtask

// Samples tx on falling edges, so every sample sits half a cycle away from a change.
task automatic decode_tx_frame(output logic [7:0] data, output logic parity_ok,
                               output logic stop_ok, output int idle_cycles);
    idle_cycles = 0;
    @(negedge clk);
    while (tx !== 1'b0) begin
        if (tx !== 1'b1) begin
            report_failure("tx was undefined while the line should have been idle.");
        end
        if (!seq_started && status.running !== 1'b0) begin
            report_failure("status.running went high while tx was still idle after reset.");
        end
        idle_cycles++;
        @(negedge clk);
    end
    seq_started = 1'b1;
    repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);  // Middle of the start bit.
    if (tx !== 1'b0) begin
        report_failure("Start bit on tx did not last until the middle of the bit.");
    end
    for (int i = 0; i < DATA_BITS; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        data[i] = tx;
    end
    parity_ok = 1'b1;
    if (PARITY_MODE != PARITY_NONE) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        parity_ok = (tx === expected_parity(data));
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    stop_ok = (tx === 1'b1);
endtask

task automatic check_tx_byte(input logic [7:0] exp, input logic [7:0] act,
                             input logic parity_ok, input logic stop_ok);
    if (act !== exp) begin
        report_failure($sformatf("[FAIL] %0t tx byte: expected %02h, got %02h",
                                 $time, exp, act));
    end
    if (parity_ok !== 1'b1) begin
        report_failure($sformatf("Frame with byte %02h on tx had a wrong parity bit.", act));
    end
    if (stop_ok !== 1'b1) begin
        report_failure($sformatf("Frame with byte %02h on tx had a low stop bit.", act));
    end
endtask

task automatic check_rx_result(input rx_result_t exp, input rx_result_t act);
    if (act.data !== exp.data) begin
        report_failure($sformatf("[FAIL] %0t rx_result.data: expected %02h, got %02h",
                                 $time, exp.data, act.data));
    end
    if (act.parity_error !== exp.parity_error) begin
        report_failure($sformatf("[FAIL] %0t rx_result.parity_error: expected %0b, got %0b",
                                 $time, exp.parity_error, act.parity_error));
    end
endtask

task automatic check_status(input link_status_t exp, input link_status_t act);
    if (act.running !== exp.running) begin
        report_failure($sformatf("[FAIL] %0t status.running: expected %0b, got %0b",
                                 $time, exp.running, act.running));
    end
    if (act.last_byte !== exp.last_byte) begin
        report_failure($sformatf("[FAIL] %0t status.last_byte: expected %02h, got %02h",
                                 $time, exp.last_byte, act.last_byte));
    end
    if (act.rx_count !== exp.rx_count) begin
        report_failure($sformatf("[FAIL] %0t status.rx_count: expected %0d, got %0d",
                                 $time, exp.rx_count, act.rx_count));
    end
    if (act.parity_seen !== exp.parity_seen) begin
        report_failure($sformatf("[FAIL] %0t status.parity_seen: expected %0b, got %0b",
                                 $time, exp.parity_seen, act.parity_seen));
    end
endtask

`endif

// File: verif/uart_link_tb.sv
`timescale 1ns/1ps

module uart_link_tb;
    import uart_pkg::*;

    localparam int TX_FRAMES     = 40;
    localparam int RX_GOOD       = 60;
    localparam int RX_BAD        = 20;
    localparam int RX_FRAMES     = RX_GOOD + RX_BAD;
    localparam int MAX_GAP       = 40;
    localparam int FRAMES_TESTED = (TX_FRAMES > RX_FRAMES) ? TX_FRAMES : RX_FRAMES;
    localparam int TIMEOUT_CYCLES =
        2 * (STARTUP_CYCLES + (FRAMES_TESTED + 2) * (FRAME_BITS * CLKS_PER_BIT + 50));

    logic         clk;
    logic         rst_n;
    logic         rx;
    logic         tx;
    rx_result_t   rx_result;
    logic         rx_done;
    link_status_t status;

    integer     seed;
    int         cycle_cnt = 0;
    rx_result_t exp_q[$];  // Results the receiver still owes in the order they were sent.

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped at the first error.");
    endtask

    `include "uart_tb_model.svh"

    uart_link_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx        (rx),
        .tx        (tx),
        .rx_result (rx_result),
        .rx_done   (rx_done),
        .status    (status)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout: the run did not finish within %0d cycles.",
                                     TIMEOUT_CYCLES));
        end
    end

    task automatic watch_tx_frames();
        logic [7:0] data;
        logic       parity_ok;
        logic       stop_ok;
        int         idle_cycles;
        for (int n = 0; n < TX_FRAMES; n++) begin
            decode_tx_frame(data, parity_ok, stop_ok, idle_cycles);
            if (n == 0 && idle_cycles < STARTUP_CYCLES) begin
                report_failure($sformatf("First frame on tx came after %0d idle cycles.",
                                         idle_cycles));
            end
            check_tx_byte({2'b00, exp_code}, data, parity_ok, stop_ok);
            exp_code++;  // The code is six bits wide and wraps from 63 to 0.
        end
    endtask

    task automatic send_random_frames();
        logic [31:0] rnd;
        logic [7:0]  data;
        logic        bad;
        int          bad_left;
        int          gap;
        rx_result_t  exp;
        bad_left = RX_BAD;
        for (int n = 0; n < RX_FRAMES; n++) begin
            rnd  = $random(seed);
            data = rnd[7:0];
            bad  = (rnd[9:8] == 2'b00) && (bad_left > 0);  // About one frame in four.
            if (bad_left == RX_FRAMES - n) begin
                bad = 1'b1;
            end
            if (bad) begin
                bad_left--;
            end
            exp.data         = data;
            exp.parity_error = bad && (PARITY_MODE != PARITY_NONE);
            exp_q.push_back(exp);
            send_rx_frame(data, bad);
            rnd = $random(seed);
            gap = rnd % (MAX_GAP + 1);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic monitor_rx_done();
        rx_result_t   exp;
        link_status_t exp_status;
        for (int n = 0; n < RX_FRAMES; n++) begin
            do begin
                @(negedge clk);
            end while (rx_done !== 1'b1);
            if (exp_q.size() == 0) begin
                report_failure("rx_done pulsed although no frame was sent on rx.");
            end
            exp = exp_q.pop_front();
            check_rx_result(exp, rx_result);
            exp_rx_count++;
            exp_last_byte   = exp.data;
            exp_parity_seen = exp_parity_seen | exp.parity_error;
            @(negedge clk);  // Status follows one cycle after rx_done.
            if (rx_done !== 1'b0) begin
                report_failure("rx_done stayed high for more than one cycle.");
            end
            exp_status.running     = seq_started;
            exp_status.last_byte   = exp_last_byte;
            exp_status.rx_count    = exp_rx_count;
            exp_status.parity_seen = exp_parity_seen;
            check_status(exp_status, status);
        end
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        seed            = 32'hd5cb_0ffd;
        rst_n           = 1'b0;
        rx              = 1'b1;  // Idle line.
        exp_code        = '0;
        exp_rx_count    = '0;
        exp_last_byte   = '0;
        exp_parity_seen = 1'b0;
        seq_started     = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fork
            watch_tx_frames();
            send_random_frames();
            monitor_rx_done();
        join
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: all.f
+incdir+include
hdl/uart_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/code_sequencer.sv
hdl/link_status.sv
hdl/uart_link_top.sv
verif/uart_link_tb.sv

// File: Bender.yml
package:
  name: uart_link

sources:
  # RTL in compile order, package first.
  - hdl/uart_pkg.sv
  - hdl/uart_tx.sv
  - hdl/uart_rx.sv
  - hdl/code_sequencer.sv
  - hdl/link_status.sv
  - hdl/uart_link_top.sv

  # Testbench top, uart_link_tb.
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/uart_link_tb.sv
